//--- src.f
+incdir+common
common/unit_pkg.sv
common/pause_pkg.sv
pause_seq_chain/pause_seq_chain.sv
verilog/pause_group.sv
pause_join/pause_join.sv
verilog/pause_ctrl.sv
tests/unit_model.sv
tests/tb_pause_ctrl.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_pause_ctrl -f src.f

output=$(./obj_dir/Vtb_pause_ctrl 2>&1 || true)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
echo "simulation did not pass"
exit 1

//--- tests/tb_pause_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "pause_macros.svh"

module tb_pause_ctrl
    import unit_pkg::*;
    import pause_pkg::*;
();

    localparam int SEQ_N   = `PAUSE_SEQ_UNITS;
    localparam int PAR_N   = `PAUSE_PAR_UNITS;
    localparam int TIMEOUT = 200;
    localparam int PHASES  = 16;

    // one row per phase. ordered marks a real pause or resume whose
    // request order is checked.
    typedef struct packed {
        logic     req;
        par_vec_t enable;
        logic     ordered;
    } phase_t;

    logic          seq;
    logic          arst_n;
    logic          pause_req;
    wire logic     pause_ack;
    par_vec_t      group_enable;
    par_vec_t      group_hold;
    wire seq_vec_t chain_unit_req;
    wire seq_vec_t chain_unit_ack;
    wire par_vec_t group_unit_req;
    wire par_vec_t group_unit_ack;

    logic [2:0] chain_delay [SEQ_N];
    logic [2:0] group_delay [PAR_N];
    phase_t     phases [PHASES];
    integer     seed = 32'h1387_4dda;
    int         cycle = 0;
    int         phase_start;
    logic       phase_req = 1'b1;
    logic       phase_ordered = 1'b0;

    // cycle of the last change of each request, and of the chain acknowledges.
    int         chain_change [SEQ_N];
    int         chain_ack_change [SEQ_N];
    int         group_change [PAR_N];
    seq_vec_t   chain_req_prev = '1;
    seq_vec_t   chain_ack_prev = '1;
    par_vec_t   group_req_prev = '1;

    pause_ctrl pause_ctrl_inst (
        .seq            (seq),
        .arst_n         (arst_n),
        .pause_req      (pause_req),
        .pause_ack      (pause_ack),
        .group_enable   (group_enable),
        .chain_unit_req (chain_unit_req),
        .chain_unit_ack (chain_unit_ack),
        .group_unit_req (group_unit_req),
        .group_unit_ack (group_unit_ack)
    );

    for (genvar g = 0; g < SEQ_N; g++) begin : chain_units
        unit_model chain_unit_inst (
            .seq    (seq),
            .arst_n (arst_n),
            .req    (chain_unit_req[g]),
            .hold   (1'b0),
            .delay  (chain_delay[g]),
            .ack    (chain_unit_ack[g])
        );
    end

    for (genvar g = 0; g < PAR_N; g++) begin : group_units
        unit_model group_unit_inst (
            .seq    (seq),
            .arst_n (arst_n),
            .req    (group_unit_req[g]),
            .hold   (group_hold[g]),
            .delay  (group_delay[g]),
            .ack    (group_unit_ack[g])
        );
    end

    initial begin
        seq = 1'b0;
        forever #5 seq = ~seq;
    end

    always @(posedge seq) cycle <= cycle + 1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_chain(input string name, input seq_vec_t got, input seq_vec_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_group(input string name, input par_vec_t got, input par_vec_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic wait_for_ack(input logic level);
        int          waited;
        join_state_t st;
        waited = 0;
        @(negedge seq);
        while (pause_ack !== level) begin
            if (waited >= TIMEOUT) begin
                st = pause_ctrl_inst.pause_join_inst.state;
                abort_run($sformatf("pause_ack never reached %0b, sequencer stuck in %s",
                                    level, st.name()));
            end
            @(negedge seq);
            waited++;
        end
    endtask

    // every unit has reached the requested level and answered it.
    task automatic wait_settled(input logic req, input par_vec_t en);
        int       waited;
        seq_vec_t exp_chain;
        par_vec_t exp_group;
        waited    = 0;
        exp_chain = {SEQ_N{req}};
        exp_group = {PAR_N{req}} & en;
        @(negedge seq);
        while (chain_unit_req !== exp_chain || chain_unit_ack !== exp_chain ||
               group_unit_req !== exp_group || group_unit_ack !== exp_group) begin
            if (waited >= TIMEOUT) begin
                abort_run("units never settled at the requested level");
            end
            @(negedge seq);
            waited++;
        end
    endtask

    task automatic verify_order(input logic pausing, input par_vec_t en, input int start);
        int first_group;
        int last_group;
        first_group = 32'h7fff_ffff;
        last_group  = 0;
        for (int i = 0; i < SEQ_N; i++) begin
            if (chain_change[i] <= start) begin
                abort_run($sformatf("chain unit %0d request did not change in this phase", i));
            end
        end
        for (int i = 0; i < PAR_N; i++) begin
            if (en[i]) begin
                if (group_change[i] <= start) begin
                    abort_run($sformatf("group unit %0d request did not change", i));
                end
                if (group_change[i] < first_group) first_group = group_change[i];
                if (group_change[i] > last_group) last_group = group_change[i];
            end
        end
        if (pausing) begin
            for (int i = 1; i < SEQ_N; i++) begin
                if (chain_change[i] <= chain_change[i-1]) begin
                    abort_run($sformatf("chain unit %0d paused no later than unit %0d", i, i-1));
                end
            end
            if (en != '0 && first_group <= chain_ack_change[SEQ_N-1]) begin
                abort_run("group paused before the last chain unit acknowledged");
            end
        end else begin
            for (int i = 0; i < SEQ_N-1; i++) begin
                if (chain_change[i] <= chain_change[i+1]) begin
                    abort_run($sformatf("chain unit %0d resumed no later than unit %0d", i, i+1));
                end
            end
            if (en != '0 && last_group >= chain_change[SEQ_N-1]) begin
                abort_run("chain resumed before the group had resumed");
            end
        end
    endtask

    // records request changes and watches the invariants each cycle.
    always @(negedge seq) begin
        for (int i = 0; i < SEQ_N; i++) begin
            if (chain_unit_req[i] !== chain_req_prev[i]) chain_change[i] = cycle;
            if (chain_unit_ack[i] !== chain_ack_prev[i]) chain_ack_change[i] = cycle;
        end
        for (int i = 0; i < PAR_N; i++) begin
            if (group_unit_req[i] !== group_req_prev[i]) group_change[i] = cycle;
        end
        chain_req_prev = chain_unit_req;
        chain_ack_prev = chain_unit_ack;
        group_req_prev = group_unit_req;
        if (arst_n) begin
            check_group("group_unit_req", group_unit_req & ~group_enable, '0);
        end
        if (phase_ordered && phase_req && pause_ack) begin
            check_chain("chain_unit_req", chain_unit_req, '1);
            check_chain("chain_unit_ack", chain_unit_ack, '1);
            check_group("group_unit_req", group_unit_req, group_enable);
            check_group("group_unit_ack", group_unit_ack & group_enable, group_enable);
        end
        if (phase_ordered && !phase_req && !pause_ack) begin
            check_chain("chain_unit_req", chain_unit_req, '0);
            check_group("group_unit_req", group_unit_req, '0);
        end
    end

    initial begin
        logic [31:0] rnd;
        phase_t      ph;
        phases[0]  = '{1'b0, par_vec_t'(4'hf), 1'b1};
        phases[1]  = '{1'b1, par_vec_t'(4'hf), 1'b1};
        phases[2]  = '{1'b0, par_vec_t'(4'hf), 1'b1};
        phases[3]  = '{1'b1, par_vec_t'(4'hf), 1'b1};
        phases[4]  = '{1'b1, par_vec_t'(4'h5), 1'b0}; // mask change while paused.
        phases[5]  = '{1'b0, par_vec_t'(4'h5), 1'b1};
        phases[6]  = '{1'b1, par_vec_t'(4'h5), 1'b1};
        phases[7]  = '{1'b1, par_vec_t'(4'ha), 1'b0};
        phases[8]  = '{1'b0, par_vec_t'(4'ha), 1'b1};
        phases[9]  = '{1'b1, par_vec_t'(4'ha), 1'b1};
        phases[10] = '{1'b1, par_vec_t'(4'h0), 1'b0}; // whole group switched off.
        phases[11] = '{1'b0, par_vec_t'(4'h0), 1'b1};
        phases[12] = '{1'b1, par_vec_t'(4'h0), 1'b1};
        phases[13] = '{1'b1, par_vec_t'(4'hf), 1'b0};
        phases[14] = '{1'b0, par_vec_t'(4'hf), 1'b1};
        phases[15] = '{1'b1, par_vec_t'(4'hf), 1'b1};

        arst_n       <= 1'b0;
        pause_req    <= 1'b1;
        group_enable <= '1;
        group_hold   <= '0;
        for (int i = 0; i < SEQ_N; i++) chain_delay[i] <= '0;
        for (int i = 0; i < PAR_N; i++) group_delay[i] <= '0;
        repeat (5) @(posedge seq);
        arst_n <= 1'b1;
        @(negedge seq);
        check_ack("pause_ack", pause_ack, 1'b1);
        check_chain("chain_unit_req", chain_unit_req, '1);
        check_group("group_unit_req", group_unit_req, group_enable);
        wait_settled(1'b1, group_enable);

        for (int p = 0; p < PHASES; p++) begin
            ph = phases[p];
            @(posedge seq);
            pause_req    <= ph.req;
            group_enable <= ph.enable;
            group_hold   <= ~ph.enable; // disabled units are told never to answer.
            for (int i = 0; i < SEQ_N; i++) begin
                rnd = $random(seed);
                chain_delay[i] <= rnd[2:0];
            end
            for (int i = 0; i < PAR_N; i++) begin
                rnd = $random(seed);
                group_delay[i] <= rnd[2:0];
            end
            phase_start   = cycle;
            phase_req     = ph.req;
            phase_ordered = ph.ordered;
            wait_for_ack(ph.req);
            wait_settled(ph.req, ph.enable);
            @(negedge seq); // let the monitor record the last change.
            check_ack("pause_ack", pause_ack, ph.req);
            check_chain("chain_unit_req", chain_unit_req, {SEQ_N{ph.req}});
            check_group("group_unit_req", group_unit_req, {PAR_N{ph.req}} & ph.enable);
            if (ph.ordered) begin
                verify_order(ph.req, ph.enable, phase_start);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/unit_model.sv
`timescale 1ns/1ns
`default_nettype none

// stallable unit stand-in. the acknowledge follows the request level
// after a delay that the testbench loads per phase.
module unit_model (
    input  wire logic       seq,
    input  wire logic       arst_n,
    input  wire logic       req,
    input  wire logic       hold,
    input  wire logic [2:0] delay,
    output logic            ack
);

    logic [2:0] count;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            ack   <= 1'b1; // units come out of reset stopped.
            count <= '0;
        end else if (hold) begin
            ack   <= 1'b0; // a held unit never answers.
            count <= '0;
        end else if (req == ack) begin
            count <= '0;
        end else if (count >= delay) begin
            ack   <= req;
            count <= '0;
        end else begin
            count <= count + 3'd1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pause_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module pause_ctrl
    import unit_pkg::*;
(
    input  wire logic     seq,
    input  wire logic     arst_n,

    input  wire logic     pause_req,
    output logic          pause_ack,

    input  wire par_vec_t group_enable,

    output seq_vec_t      chain_unit_req,
    input  wire seq_vec_t chain_unit_ack,

    output par_vec_t      group_unit_req,
    input  wire par_vec_t group_unit_ack
);

    logic chain_req;
    logic chain_ack;
    logic group_req;
    logic group_ack;

    pause_join pause_join_inst (
        .seq       (seq),
        .arst_n    (arst_n),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .chain_req (chain_req),
        .chain_ack (chain_ack),
        .group_req (group_req),
        .group_ack (group_ack)
    );

    pause_seq_chain pause_seq_chain_inst (
        .seq            (seq),
        .arst_n         (arst_n),
        .chain_req      (chain_req),
        .chain_ack      (chain_ack),
        .chain_unit_req (chain_unit_req),
        .chain_unit_ack (chain_unit_ack)
    );

    pause_group pause_group_inst (
        .seq            (seq),
        .arst_n         (arst_n),
        .group_req      (group_req),
        .group_ack      (group_ack),
        .group_enable   (group_enable),
        .group_unit_req (group_unit_req),
        .group_unit_ack (group_unit_ack)
    );

endmodule

`default_nettype wire

//--- pause_join/pause_join.sv
`timescale 1ns/1ns
`default_nettype none

module pause_join
    import pause_pkg::*;
(
    input  wire logic seq,
    input  wire logic arst_n,

    input  wire logic pause_req,
    output logic      pause_ack,

    output logic      chain_req,
    input  wire logic chain_ack,

    output logic      group_req,
    input  wire logic group_ack
);

    join_state_t state;
    join_state_t state_nx;

    // pause quiets the chain before the group.
    // resume releases the group before the chain.
    always_comb begin
        state_nx = state;
        case (state)
            paused: begin
                if (!pause_req) begin
                    state_nx = release_group;
                end
            end
            release_group: begin
                if (!group_ack) begin
                    state_nx = release_chain;
                end
            end
            release_chain: begin
                if (!chain_ack) begin
                    state_nx = running;
                end
            end
            running: begin
                if (pause_req) begin
                    state_nx = quiet_chain;
                end
            end
            quiet_chain: begin
                if (chain_ack) begin
                    state_nx = quiet_group;
                end
            end
            quiet_group: begin
                if (group_ack) begin
                    state_nx = paused;
                end
            end
            default: begin
                state_nx = paused; // unused codes fall back to a safe stop.
            end
        endcase
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            state <= paused;
        end else begin
            state <= state_nx;
        end
    end

    // outputs are registered and decoded from the next state,
    // so they change on the same edge as the state.
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            chain_req <= 1'b1;
            group_req <= 1'b1;
            pause_ack <= 1'b1;
        end else begin
            chain_req <= (state_nx != release_chain) && (state_nx != running);
            group_req <= (state_nx == paused) || (state_nx == quiet_group);
            // falls once both groups run, rises once both are quiet.
            pause_ack <= (state_nx != running) && (state_nx != quiet_chain)
                         && (state_nx != quiet_group);
        end
    end

endmodule

`default_nettype wire

//--- verilog/pause_group.sv
`timescale 1ns/1ns
`default_nettype none

`include "pause_macros.svh"

module pause_group
    import unit_pkg::*;
(
    input  wire logic     seq,
    input  wire logic     arst_n,

    input  wire logic     group_req,
    output logic          group_ack,

    input  wire par_vec_t group_enable,

    output par_vec_t      group_unit_req,
    input  wire par_vec_t group_unit_ack
);

    localparam int N = `PAUSE_PAR_UNITS;

    par_vec_t req_q;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= '1;
        end else begin
            for (int i = 0; i < N; i++) begin
                req_q[i] <= group_req; // all units see the request together.
            end
        end
    end

    assign group_unit_req = req_q & group_enable; // switched-off units never see a request.

    // only enabled units count, so an empty mask gives back group_req.
    always_comb begin
        if (group_req) begin
            group_ack = &(group_unit_ack | ~group_enable);
        end else begin
            group_ack = |(group_unit_ack & group_enable);
        end
    end

endmodule

`default_nettype wire

//--- pause_seq_chain/pause_seq_chain.sv
`timescale 1ns/1ns
`default_nettype none

`include "pause_macros.svh"

module pause_seq_chain
    import unit_pkg::*;
(
    input  wire logic     seq,
    input  wire logic     arst_n,

    input  wire logic     chain_req,
    output logic          chain_ack,

    output seq_vec_t      chain_unit_req,
    input  wire seq_vec_t chain_unit_ack
);

    localparam int N = `PAUSE_SEQ_UNITS;

    // unit requests ripple upward on pause and downward on resume.
    // each step waits until the neighbour's request and acknowledge agree.
    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            chain_unit_req <= '1; // everything starts paused.
        end else if (chain_req) begin
            chain_unit_req[0] <= 1'b1;
            for (int i = 1; i < N; i++) begin
                // unit i follows once unit i-1 is stopped.
                chain_unit_req[i] <= chain_unit_req[i-1] && chain_unit_ack[i-1];
            end
        end else begin
            chain_unit_req[N-1] <= 1'b0;
            for (int i = 0; i < N-1; i++) begin
                // stays high until unit i+1 runs again.
                chain_unit_req[i] <= chain_unit_req[i+1] || chain_unit_ack[i+1];
            end
        end
    end

    // combined acknowledge.
    // pausing needs every unit stopped, resuming needs every unit running.
    always_comb begin
        if (chain_req) begin
            chain_ack = 1'b1;
            for (int i = 0; i < N; i++) begin
                chain_ack &= chain_unit_ack[i];
            end
        end else begin
            chain_ack = 1'b0;
            for (int i = 0; i < N; i++) begin
                chain_ack |= chain_unit_ack[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- common/pause_pkg.sv
`default_nettype none

package pause_pkg;

    // states of the join sequencer.
    // resume walks paused -> release_group -> release_chain -> running,
    // pause walks running -> quiet_chain -> quiet_group -> paused.
    typedef enum logic [2:0] {
        paused        = 3'd0,
        release_group = 3'd1,
        release_chain = 3'd2,
        running       = 3'd3,
        quiet_chain   = 3'd4,
        quiet_group   = 3'd5
    } join_state_t;

endpackage

`default_nettype wire

//--- common/unit_pkg.sv
`default_nettype none

`include "pause_macros.svh"

package unit_pkg;

    // one bit per unit of the chain group.
    typedef logic [`PAUSE_SEQ_UNITS-1:0] seq_vec_t;

    typedef logic [`PAUSE_PAR_UNITS-1:0] par_vec_t; // one bit per parallel unit.

endpackage

`default_nettype wire

//--- common/pause_macros.svh
`ifndef PAUSE_MACROS_SVH
`define PAUSE_MACROS_SVH

// number of units paused one after another.
`define PAUSE_SEQ_UNITS 4

// number of units paused together, each with its own enable bit.
`define PAUSE_PAR_UNITS 4

`endif
